// File: src/flight_pkg.sv
package flight_pkg;

	// one word each, two's complement
	typedef logic signed [15:0] rate_t;
	typedef logic signed [15:0] imu_val_t;
	typedef logic signed [15:0] angle_t;

	// roll in the upper bits, yaw in the lower bits
	typedef struct packed {
		rate_t roll;
		rate_t pitch;
		rate_t yaw;
	} axis_rate_t;

	typedef struct packed {
		imu_val_t roll;
		imu_val_t pitch;
		imu_val_t yaw;
	} axis_imu_t;

	typedef struct packed {
		angle_t roll;
		angle_t pitch;
		angle_t yaw;
	} axis_angle_t;

	typedef enum logic [2:0] {
		PID_WAIT,
		PID_CALC1,
		PID_CALC2,
		PID_CALC3,
		PID_CALC4,
		PID_COMPLETE
	} pid_state_t;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_LATCH,
		SEQ_RUN,
		SEQ_PUBLISH
	} seq_state_t;

endpackage

// File: src/pid.sv
module pid
	import flight_pkg::*;
#(
	parameter logic signed [15:0] K_P      = 16'sd1,
	parameter logic signed [15:0] K_I      = 16'sd1,
	parameter logic signed [15:0] K_D      = 16'sd1,
	parameter rate_t              RATE_MIN = 16'sh8000,
	parameter rate_t              RATE_MAX = 16'sh7fff
) (
	input  logic     us_clk,
	input  logic     resetn,
	input  logic     start_flag,
	input  logic     wait_flag,
	input  rate_t    target_rotation,
	input  imu_val_t actual_rotation,
	input  rate_t    angle_error,
	output rate_t    rate_out,
	output logic     pid_complete,
	output logic     pid_active
);

	// each stage wide enough that it cannot overflow
	localparam int ERR_W  = 17;
	localparam int CHG_W  = 18;
	localparam int INT_W  = 32;
	localparam int PROP_W = 33;
	localparam int DER_W  = 34;
	localparam int SUM_W  = 36;

	pid_state_t state;
	pid_state_t next_state;

	// inputs held for the whole calculation
	rate_t    target_q;
	imu_val_t actual_q;
	rate_t    angle_q;

	logic signed [ERR_W-1:0]  rate_err;
	logic signed [ERR_W-1:0]  prev_err;
	logic signed [CHG_W-1:0]  err_change;
	logic signed [INT_W-1:0]  i_term;
	logic signed [PROP_W-1:0] p_term;
	logic signed [DER_W-1:0]  d_term;
	logic signed [SUM_W-1:0]  pid_sum;
	rate_t                    sum_clamped;

	assign pid_active = (state != PID_WAIT);

	always_comb begin
		case (state)
			PID_WAIT:     next_state = start_flag ? PID_CALC1 : PID_WAIT;
			PID_CALC1:    next_state = PID_CALC2;
			PID_CALC2:    next_state = PID_CALC3;
			PID_CALC3:    next_state = PID_CALC4;
			PID_CALC4:    next_state = PID_COMPLETE;
			PID_COMPLETE: next_state = wait_flag ? PID_WAIT : PID_COMPLETE;
			default:      next_state = PID_WAIT;
		endcase
	end

	// limit the wide sum to the configured rate range
	always_comb begin
		if (pid_sum < RATE_MIN)
			sum_clamped = RATE_MIN;
		else if (pid_sum > RATE_MAX)
			sum_clamped = RATE_MAX;
		else
			sum_clamped = rate_t'(pid_sum);
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state        <= PID_WAIT;
			prev_err     <= '0;
			rate_out     <= '0;
			pid_complete <= 1'b0;
		end else begin
			state <= next_state;
			// error of this run becomes the reference for the next one
			if (state == PID_CALC2)
				prev_err <= rate_err;
			if (state == PID_COMPLETE)
				rate_out <= sum_clamped;
			pid_complete <= (state == PID_COMPLETE) && !wait_flag;
		end
	end

	always_ff @(posedge us_clk) begin
		case (state)
			PID_WAIT: begin
				if (start_flag) begin
					target_q <= target_rotation;
					actual_q <= actual_rotation;
					angle_q  <= angle_error;
				end
			end
			PID_CALC1: begin
				rate_err <= target_q - actual_q;
				// angle error stands in for the integrated rate error
				i_term   <= K_I * angle_q;
			end
			PID_CALC2: begin
				p_term     <= K_P * rate_err;
				err_change <= prev_err - rate_err;
			end
			PID_CALC3: begin
				d_term <= K_D * err_change;
			end
			PID_CALC4: begin
				pid_sum <= p_term + i_term + d_term;
			end
			default: begin
			end
		endcase
	end

endmodule

// File: src/angle_error_calc.sv
module angle_error_calc
	import flight_pkg::*;
(
	input  logic        us_clk,
	input  logic        resetn,
	input  logic        start,
	input  logic        busy,
	input  axis_angle_t target_angle,
	input  axis_angle_t actual_angle,
	output axis_rate_t  angle_err
);

	localparam logic signed [16:0] DIFF_MAX = 17'sd32767;
	localparam logic signed [16:0] DIFF_MIN = -17'sd32768;

	logic capture;

	// target minus measured, pinned to the 16-bit range
	function automatic rate_t sat_diff(input angle_t tgt, input angle_t act);
		logic signed [16:0] diff;
		diff = tgt - act;
		if (diff > DIFF_MAX)
			return rate_t'(DIFF_MAX);
		else if (diff < DIFF_MIN)
			return rate_t'(DIFF_MIN);
		else
			return rate_t'(diff);
	endfunction

	// a start during a run belongs to nobody
	assign capture = start && !busy;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			angle_err <= '0;
		end else if (capture) begin
			angle_err <= '{
				roll:  sat_diff(target_angle.roll, actual_angle.roll),
				pitch: sat_diff(target_angle.pitch, actual_angle.pitch),
				yaw:   sat_diff(target_angle.yaw, actual_angle.yaw)
			};
		end
	end

endmodule

// File: src/rate_controller.sv
module rate_controller
	import flight_pkg::*;
#(
	parameter logic signed [15:0] K_P      = 16'sd1,
	parameter logic signed [15:0] K_I      = 16'sd1,
	parameter logic signed [15:0] K_D      = 16'sd1,
	parameter rate_t              RATE_MIN = 16'sh8000,
	parameter rate_t              RATE_MAX = 16'sh7fff
) (
	input  logic       us_clk,
	input  logic       resetn,
	input  logic       start,
	input  axis_rate_t target_rate,
	input  axis_imu_t  actual_rate,
	input  axis_rate_t angle_err,
	output axis_rate_t rate_out,
	output logic       busy,
	output logic       done
);

	seq_state_t state;
	seq_state_t next_state;

	axis_rate_t target_q;
	axis_imu_t  actual_q;

	logic       start_flag;
	logic       wait_flag;
	logic [2:0] pid_complete;
	logic       all_complete;
	rate_t      roll_rate;
	rate_t      pitch_rate;
	rate_t      yaw_rate;

	assign busy         = (state != SEQ_IDLE);
	assign all_complete = &pid_complete;

	always_comb begin
		case (state)
			SEQ_IDLE:    next_state = start ? SEQ_LATCH : SEQ_IDLE;
			SEQ_LATCH:   next_state = SEQ_RUN;
			// all three units take the same number of cycles
			SEQ_RUN:     next_state = all_complete ? SEQ_PUBLISH : SEQ_RUN;
			SEQ_PUBLISH: next_state = SEQ_IDLE;
			default:     next_state = SEQ_IDLE;
		endcase
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state      <= SEQ_IDLE;
			start_flag <= 1'b0;
			wait_flag  <= 1'b0;
			done       <= 1'b0;
			rate_out   <= '0;
		end else begin
			state      <= next_state;
			start_flag <= (state == SEQ_LATCH);
			// release the units in the same cycle as done
			wait_flag  <= (state == SEQ_PUBLISH);
			done       <= (state == SEQ_PUBLISH);
			if (state == SEQ_PUBLISH)
				rate_out <= '{roll: roll_rate, pitch: pitch_rate, yaw: yaw_rate};
		end
	end

	// rate inputs are only valid alongside start
	always_ff @(posedge us_clk) begin
		if (state == SEQ_IDLE && start) begin
			target_q <= target_rate;
			actual_q <= actual_rate;
		end
	end

	pid #(
		.K_P(K_P), .K_I(K_I), .K_D(K_D), .RATE_MIN(RATE_MIN), .RATE_MAX(RATE_MAX)
	) u_pid_roll (
		.us_clk          (us_clk),
		.resetn          (resetn),
		.start_flag      (start_flag),
		.wait_flag       (wait_flag),
		.target_rotation (target_q.roll),
		.actual_rotation (actual_q.roll),
		.angle_error     (angle_err.roll),
		.rate_out        (roll_rate),
		.pid_complete    (pid_complete[2]),
		.pid_active      ()
	);

	pid #(
		.K_P(K_P), .K_I(K_I), .K_D(K_D), .RATE_MIN(RATE_MIN), .RATE_MAX(RATE_MAX)
	) u_pid_pitch (
		.us_clk          (us_clk),
		.resetn          (resetn),
		.start_flag      (start_flag),
		.wait_flag       (wait_flag),
		.target_rotation (target_q.pitch),
		.actual_rotation (actual_q.pitch),
		.angle_error     (angle_err.pitch),
		.rate_out        (pitch_rate),
		.pid_complete    (pid_complete[1]),
		.pid_active      ()
	);

	pid #(
		.K_P(K_P), .K_I(K_I), .K_D(K_D), .RATE_MIN(RATE_MIN), .RATE_MAX(RATE_MAX)
	) u_pid_yaw (
		.us_clk          (us_clk),
		.resetn          (resetn),
		.start_flag      (start_flag),
		.wait_flag       (wait_flag),
		.target_rotation (target_q.yaw),
		.actual_rotation (actual_q.yaw),
		.angle_error     (angle_err.yaw),
		.rate_out        (yaw_rate),
		.pid_complete    (pid_complete[0]),
		.pid_active      ()
	);

endmodule

// File: src/flight_rate_top.sv
module flight_rate_top
	import flight_pkg::*;
#(
	parameter logic signed [15:0] K_P      = 16'sd1,
	parameter logic signed [15:0] K_I      = 16'sd1,
	parameter logic signed [15:0] K_D      = 16'sd1,
	parameter rate_t              RATE_MIN = 16'sh8000,
	parameter rate_t              RATE_MAX = 16'sh7fff
) (
	input  logic        us_clk,
	input  logic        resetn,
	input  logic        start,
	input  axis_rate_t  target_rate,
	input  axis_imu_t   actual_rate,
	input  axis_angle_t target_angle,
	input  axis_angle_t actual_angle,
	output axis_rate_t  rate_out,
	output logic        busy,
	output logic        done
);

	// saturated angle error, stable for the whole run
	axis_rate_t angle_err;

	angle_error_calc u_angle_error_calc (
		.us_clk       (us_clk),
		.resetn       (resetn),
		.start        (start),
		.busy         (busy),
		.target_angle (target_angle),
		.actual_angle (actual_angle),
		.angle_err    (angle_err)
	);

	rate_controller #(
		.K_P      (K_P),
		.K_I      (K_I),
		.K_D      (K_D),
		.RATE_MIN (RATE_MIN),
		.RATE_MAX (RATE_MAX)
	) u_rate_controller (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.start       (start),
		.target_rate (target_rate),
		.actual_rate (actual_rate),
		.angle_err   (angle_err),
		.rate_out    (rate_out),
		.busy        (busy),
		.done        (done)
	);

endmodule

// File: sim/tb_flight_rate_top.sv
module tb_flight_rate_top
	import flight_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int K_P = 2;
	localparam int K_I = 1;
	localparam int K_D = 3;
	localparam int RATE_MIN = -1000;
	localparam int RATE_MAX = 1000;
	localparam int CLK_PERIOD = 4;
	localparam int N_FIXED = 7;
	localparam int N_RANDOM = 8;
	localparam int N_ROWS = N_FIXED + N_RANDOM;

	// in_busy rows are started while the previous run is busy
	typedef struct packed {
		logic        in_busy;
		axis_rate_t  tr;
		axis_imu_t   ar;
		axis_angle_t ta;
		axis_angle_t aa;
	} row_t;

	logic        us_clk;
	logic        resetn;
	logic        start;
	axis_rate_t  target_rate;
	axis_imu_t   actual_rate;
	axis_angle_t target_angle;
	axis_angle_t actual_angle;
	axis_rate_t  rate_out;
	logic        busy;
	logic        done;

	row_t   rows[$];
	int     prev_err[3];
	integer seed;

	flight_rate_top #(
		.K_P      (16'sd2),
		.K_I      (16'sd1),
		.K_D      (16'sd3),
		.RATE_MIN (-16'sd1000),
		.RATE_MAX (16'sd1000)
	) i_dut (
		.us_clk       (us_clk),
		.resetn       (resetn),
		.start        (start),
		.target_rate  (target_rate),
		.actual_rate  (actual_rate),
		.target_angle (target_angle),
		.actual_angle (actual_angle),
		.rate_out     (rate_out),
		.busy         (busy),
		.done         (done)
	);

	initial begin
		us_clk = 1'b0;
		forever #(CLK_PERIOD / 2) us_clk = ~us_clk;
	end

	// 20 cycles per row plus the reset time
	initial begin
		#((N_ROWS * 20 + 2) * CLK_PERIOD);
		$display("timeout: done never arrived");
		abort_run();
	end

	task automatic abort_run();
		$display("Verification failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic compare_word(input string name, input rate_t exp, input rate_t act);
		assert (act === exp) else begin
			$display("CHECK FAILED: %s expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic compare_out(input axis_rate_t exp);
		compare_word("rate_out.roll", exp.roll, rate_out.roll);
		compare_word("rate_out.pitch", exp.pitch, rate_out.pitch);
		compare_word("rate_out.yaw", exp.yaw, rate_out.yaw);
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond === 1'b1) else begin
			$display("%s", what);
			abort_run();
		end
	endtask

	// reference for one axis that keeps the rate error for the next run
	function automatic rate_t model_axis(input int ax, input rate_t tr, input imu_val_t ar,
			input angle_t ta, input angle_t aa);
		int ae;
		int err;
		int sum;
		ae = int'(ta) - int'(aa);
		if (ae > 32767)
			ae = 32767;
		else if (ae < -32768)
			ae = -32768;
		err = int'(tr) - int'(ar);
		sum = K_P * err + K_I * ae + K_D * (prev_err[ax] - err);
		prev_err[ax] = err;
		if (sum < RATE_MIN)
			sum = RATE_MIN;
		else if (sum > RATE_MAX)
			sum = RATE_MAX;
		return rate_t'(sum);
	endfunction

	function automatic axis_rate_t model_row(input row_t r);
		axis_rate_t res;
		res.roll  = model_axis(0, r.tr.roll, r.ar.roll, r.ta.roll, r.aa.roll);
		res.pitch = model_axis(1, r.tr.pitch, r.ar.pitch, r.ta.pitch, r.aa.pitch);
		res.yaw   = model_axis(2, r.tr.yaw, r.ar.yaw, r.ta.yaw, r.aa.yaw);
		return res;
	endfunction

	function automatic rate_t small_rand();
		return rate_t'($random(seed) % 400);
	endfunction

	function automatic rate_t full_rand();
		int v;
		v = $random(seed);
		return rate_t'(v);
	endfunction

	task automatic add_row(input logic in_busy, input axis_rate_t tr, input axis_imu_t ar,
			input axis_angle_t ta, input axis_angle_t aa);
		row_t r;
		r = {in_busy, tr, ar, ta, aa};
		rows.push_back(r);
	endtask

	task automatic drive_row(input row_t r);
		target_rate  = r.tr;
		actual_rate  = r.ar;
		target_angle = r.ta;
		actual_angle = r.aa;
	endtask

	task automatic tick();
		@(posedge us_clk);
		#1;
	endtask

	initial begin
		row_t       cur;
		axis_rate_t expected;
		axis_rate_t last_out;
		int         idx;
		int         cycles;
		resetn       = 1'b0;
		start        = 1'b0;
		target_rate  = '0;
		actual_rate  = '0;
		target_angle = '0;
		actual_angle = '0;
		seed         = 32'h609b_8e9c;
		prev_err     = '{0, 0, 0};

		// small values, then changing measured rates for the derivative
		add_row(0, {16'sd10, -16'sd5, 16'sd3}, {16'sd4, 16'sd2, -16'sd1},
			{16'sd20, -16'sd10, 16'sd5}, {16'sd15, -16'sd4, 16'sd5});
		add_row(0, {16'sd10, -16'sd5, 16'sd3}, {16'sd1, 16'sd8, -16'sd3},
			{16'sd20, -16'sd10, 16'sd5}, {16'sd15, -16'sd4, 16'sd5});
		add_row(0, {16'sd12, -16'sd5, 16'sd40}, {16'sd7, -16'sd2, 16'sd0},
			{16'sd2, 16'sd9, -16'sd6}, {16'sd1, 16'sd3, 16'sd0});
		// clamping and a yaw angle difference beyond 16 bits
		add_row(0, {16'sd2000, -16'sd2000, 16'sd0}, {16'sd0, 16'sd0, 16'sd0},
			{16'sd0, 16'sd0, 16'sd20000}, {16'sd0, 16'sd0, -16'sd20000});
		add_row(1, {-16'sd500, 16'sd700, 16'sd300}, {16'sd9, -16'sd9, 16'sd9},
			{16'sd30000, 16'sd0, -16'sd30000}, {-16'sd30000, 16'sd0, 16'sd30000});
		add_row(0, {16'sd0, 16'sd0, 16'sd0}, {16'sd0, 16'sd0, 16'sd0},
			{-16'sd20000, 16'sd100, 16'sd0}, {16'sd20000, 16'sd0, 16'sd0});
		add_row(0, {16'sd30, 16'sd15, -16'sd8}, {16'sd25, 16'sd20, -16'sd2},
			{16'sd5, -16'sd3, 16'sd1}, {16'sd1, 16'sd1, 16'sd1});
		for (int r = 0; r < N_RANDOM; r++) begin
			if (r % 2 == 0)
				add_row(r % 4 == 3, {small_rand(), small_rand(), small_rand()},
					{small_rand(), small_rand(), small_rand()},
					{small_rand(), small_rand(), small_rand()},
					{small_rand(), small_rand(), small_rand()});
			else
				add_row(r % 4 == 3, {small_rand(), small_rand(), small_rand()},
					{small_rand(), small_rand(), small_rand()},
					{full_rand(), full_rand(), full_rand()},
					{full_rand(), full_rand(), full_rand()});
		end

		repeat (2) @(posedge us_clk);
		#1;
		resetn = 1'b1;
		tick();
		last_out = '0;
		compare_out(last_out);
		check_true(!busy, "busy is high after reset");
		check_true(!done, "done is high after reset");

		idx = 0;
		while (idx < rows.size()) begin
			cur = rows[idx];
			idx++;
			expected = model_row(cur);
			drive_row(cur);
			start = 1'b1;
			tick();
			start = 1'b0;
			check_true(busy, "busy did not rise on the start edge");
			cycles = 0;
			while (!done) begin
				// previous result must hold until the next done
				compare_out(last_out);
				// second start lands in the latch cycle, before the units take their inputs
				if (cycles == 0 && idx < rows.size() && rows[idx].in_busy) begin
					drive_row(rows[idx]);
					start = 1'b1;
					idx++;
				end
				tick();
				cycles++;
				start = 1'b0;
			end
			check_true(cycles == 9, $sformatf("done came %0d cycles after start, not 9", cycles));
			check_true(!busy, "busy still high when done rose");
			compare_out(expected);
			last_out = expected;
			tick();
			check_true(!done, "done stayed high for more than one cycle");
			compare_out(last_out);
		end

		$display("Verification passed");
		$finish;
	end

endmodule

// File: build.f
src/flight_pkg.sv
src/pid.sv
src/angle_error_calc.sv
src/rate_controller.sv
src/flight_rate_top.sv
sim/tb_flight_rate_top.sv
